//--- mem_ctrl_defs.svh
`ifndef MEM_CTRL_DEFS_SVH
`define MEM_CTRL_DEFS_SVH

// ------------------------------
// Instruction cache geometry
// ------------------------------

// Number of cache index bits, each index holds one 16-bit word
`define CACHE_INDEX_BITS 6

// The tag is whatever is left of the 16-bit word address
`define CACHE_TAG_BITS (16 - `CACHE_INDEX_BITS)

// Number of direct mapped entries
`define CACHE_ENTRIES (1 << `CACHE_INDEX_BITS)

// ------------------------------
// External bus timing
// ------------------------------

// Clocks spent on each byte of the byte-wide RAM
`define BYTE_CYCLES 4

// A full access moves two bytes, low byte first
`define ACCESS_CYCLES (2 * `BYTE_CYCLES)

// Address width of the 512K x 8 static RAM
`define RAM_ADDR_BITS 19

`endif

//--- mem_ctrl_pkg.sv
`include "mem_ctrl_defs.svh"

package mem_ctrl_pkg;

   // ------------------------------
   // Bus and RAM data types
   // ------------------------------

   // One word on the 16-bit processor bus, used for data and addresses
   typedef logic [15:0] word_t;

   // One datum of the byte-wide external RAM
   typedef logic [7:0] byte_t;

   // ------------------------------
   // Cache types
   // ------------------------------

   // Upper address bits that are not used to index the cache
   typedef logic [`CACHE_TAG_BITS-1:0] cache_tag_t;

   // One cache line holds a single word
   // The valid field is kept in a register vector in the cache so that
   // reset can clear it without touching the entry array
   typedef struct packed {
      cache_tag_t tag;
      logic       valid;
      word_t      data;
   } cache_entry_t;

   // ------------------------------
   // Sequencer types
   // ------------------------------

   // Position of the current clock within an eight clock external access
   // Counts 0 to 3 belong to the low byte and 4 to 7 to the high byte
   typedef logic [2:0] access_count_t;

endpackage

//--- instr_cache.sv
`include "mem_ctrl_defs.svh"

module instr_cache import mem_ctrl_pkg::*; (
   input  logic  clock,
   input  logic  reset_b,
   input  logic  vpa,
   input  logic  cpu_rnw,
   input  word_t cpu_addr,
   input  word_t cpu_dout,
   input  word_t ram_word,
   input  logic  access_done,
   output logic  cache_hit,
   output word_t ext_dout
);

   // ------------------------------
   // Address decode and lookup
   // ------------------------------

   // The low address bits pick the entry and the rest form the tag
   logic [`CACHE_INDEX_BITS-1:0] addr_index;
   cache_tag_t                   addr_tag;

   // Entry array without reset, valid bits held apart
   cache_entry_t                 entry_mem [`CACHE_ENTRIES];
   logic [`CACHE_ENTRIES-1:0]    valid_q;

   cache_entry_t                 rd_entry;
   cache_entry_t                 wr_entry;
   logic                         tag_match;
   logic                         fill;
   logic                         update;

   assign addr_index = cpu_addr[`CACHE_INDEX_BITS-1:0];
   assign addr_tag   = cpu_addr[15:`CACHE_INDEX_BITS];

   // The looked-up entry takes its valid bit from the reset-cleared vector
   always_comb begin
      rd_entry       = entry_mem[addr_index];
      rd_entry.valid = valid_q[addr_index];
   end

   assign tag_match = rd_entry.valid && (rd_entry.tag == addr_tag);

   // Only instruction fetches are served from the cache
   assign cache_hit = vpa && cpu_rnw && tag_match;

   // ------------------------------
   // Fill and write-through update
   // ------------------------------

   // A fetch miss is written into the cache on the last clock of its access
   assign fill = access_done && cpu_rnw && vpa;

   // A processor write to a cached word keeps the cached copy coherent
   assign update = access_done && !cpu_rnw && tag_match;

   // Fill takes the word assembled from RAM, an update takes the write data
   always_comb begin
      wr_entry.tag   = addr_tag;
      wr_entry.valid = 1'b1;
      wr_entry.data  = fill ? ram_word : cpu_dout;
   end

   always_ff @(posedge clock) begin
      if (fill || update) begin
         entry_mem[addr_index] <= wr_entry;
      end
   end

   // Valid bits only ever get set by a fill, a write never creates an entry
   always_ff @(posedge clock) begin
      if (!reset_b) begin
         valid_q <= '0;
      end else if (fill) begin
         valid_q[addr_index] <= 1'b1;
      end
   end

   // A hit returns the cached word at once, anything else the RAM word
   assign ext_dout = cache_hit ? rd_entry.data : ram_word;

   // ------------------------------
   // Checks
   // ------------------------------

   // The sequencer must never have run an access for a word that was cached
   a_no_fill_on_hit : assert property (
      @(posedge clock) disable iff (!reset_b)
      fill |-> !cache_hit
   ) else $error("cache fill while cache_hit is high");

endmodule

//--- ext_bus_sequencer.sv
`include "mem_ctrl_defs.svh"

module ext_bus_sequencer import mem_ctrl_pkg::*; (
   input  logic  clock,
   input  logic  reset_b,
   input  logic  ext_cs_b,
   input  logic  cpu_rnw,
   input  logic  cache_hit,
   input  word_t cpu_addr,
   input  word_t cpu_dout,
   input  byte_t ram_rdata,
   output logic  cpu_clken,
   output logic  access_done,
   output logic  byte_sel,
   output logic  ram_we_b,
   output byte_t ram_wdata,
   output word_t ram_word
);

   // Bits of the count that give the clock position within one byte cycle
   localparam int PHASE_BITS = $clog2(`BYTE_CYCLES);

   // Last clock of the whole access and of the low byte
   localparam access_count_t LAST_COUNT = access_count_t'(`ACCESS_CYCLES - 1);
   localparam access_count_t LOW_LAST   = access_count_t'(`BYTE_CYCLES - 1);
   localparam access_count_t HIGH_FIRST = access_count_t'(`BYTE_CYCLES);

   access_count_t         count;
   access_count_t         count_next;
   logic [PHASE_BITS-1:0] phase_next;
   logic                  access_req;
   logic                  we_b_next;
   byte_t                 low_byte_q;

   // ------------------------------
   // Access count
   // ------------------------------

   // Any access the cache cannot serve goes out to the RAM
   assign access_req = !ext_cs_b && !cache_hit;

   // The count leaves zero on a request and then runs to the end by itself
   always_comb begin
      if (count != '0 || access_req) begin
         count_next = access_count_t'(count + 1'b1);
      end else begin
         count_next = '0;
      end
   end

   always_ff @(posedge clock) begin
      if (!reset_b) begin
         count <= '0;
      end else begin
         count <= count_next;
      end
   end

   // The processor is stalled for every clock of the access but the last
   assign cpu_clken = !(access_req && count != LAST_COUNT);

   assign access_done = (count == LAST_COUNT);

   // The low byte is accessed first, then the high byte
   assign byte_sel = (count >= HIGH_FIRST);

   // ------------------------------
   // Write strobe and write data
   // ------------------------------

   // The strobe covers clocks 1 and 2 of each byte cycle, leaving one clock
   // of address and data setup before it and one clock of hold after it
   assign phase_next = count_next[PHASE_BITS-1:0];
   assign we_b_next  = !(!cpu_rnw && phase_next >= 1 && phase_next <= `BYTE_CYCLES - 2);

   // Registered so the RAM sees a clean strobe with no decode glitches
   always_ff @(posedge clock) begin
      if (!reset_b) begin
         ram_we_b <= 1'b1;
      end else begin
         ram_we_b <= we_b_next;
      end
   end

   assign ram_wdata = byte_sel ? cpu_dout[15:8] : cpu_dout[7:0];

   // ------------------------------
   // Read word assembly
   // ------------------------------

   // The low byte is captured at the end of its cycle
   always_ff @(posedge clock) begin
      if (count == LOW_LAST) begin
         low_byte_q <= ram_rdata;
      end
   end

   // The high byte comes straight from the RAM during the last clock
   assign ram_word = {ram_rdata, low_byte_q};

   // ------------------------------
   // Checks
   // ------------------------------

   // A cached word never sits inside an external access
   a_no_count_on_hit : assert property (
      @(posedge clock) disable iff (!reset_b)
      cache_hit |-> (count == '0)
   ) else $error("cache_hit high during an external access");

   // The processor holds its request for as long as it is stalled
   a_stall_stable : assert property (
      @(posedge clock) disable iff (!reset_b)
      !cpu_clken |=> $stable(ext_cs_b) && $stable(cpu_rnw) &&
                     $stable(cpu_addr) && $stable(cpu_dout)
   ) else $error("processor inputs changed while cpu_clken is low");

   // The strobe register only ever fires for a write
   a_we_only_write : assert property (
      @(posedge clock) disable iff (!reset_b)
      !ram_we_b |-> !cpu_rnw
   ) else $error("ram_we_b low during a read");

endmodule

//--- memory_controller.sv
`include "mem_ctrl_defs.svh"

module memory_controller import mem_ctrl_pkg::*; (
   input  logic                      clock,
   input  logic                      reset_b,

   // Processor side
   input  logic                      ext_cs_b,
   input  logic                      vpa,
   input  logic                      cpu_rnw,
   input  word_t                     cpu_addr,
   input  word_t                     cpu_dout,
   output logic                      cpu_clken,
   output word_t                     ext_dout,

   // Byte-wide static RAM side
   output logic                      ram_cs_b,
   output logic                      ram_oe_b,
   output logic                      ram_we_b,
   output logic [`RAM_ADDR_BITS-1:0] ram_addr,
   output byte_t                     ram_wdata,
   output logic                      ram_wdata_oe,
   input  byte_t                     ram_rdata
);

   logic  cache_hit;
   logic  access_done;
   logic  byte_sel;
   word_t ram_word;

   // ------------------------------
   // Blocks
   // ------------------------------

   instr_cache u_instr_cache (
      .clock       (clock),
      .reset_b     (reset_b),
      .vpa         (vpa),
      .cpu_rnw     (cpu_rnw),
      .cpu_addr    (cpu_addr),
      .cpu_dout    (cpu_dout),
      .ram_word    (ram_word),
      .access_done (access_done),
      .cache_hit   (cache_hit),
      .ext_dout    (ext_dout)
   );

   ext_bus_sequencer u_ext_bus_sequencer (
      .clock       (clock),
      .reset_b     (reset_b),
      .ext_cs_b    (ext_cs_b),
      .cpu_rnw     (cpu_rnw),
      .cache_hit   (cache_hit),
      .cpu_addr    (cpu_addr),
      .cpu_dout    (cpu_dout),
      .ram_rdata   (ram_rdata),
      .cpu_clken   (cpu_clken),
      .access_done (access_done),
      .byte_sel    (byte_sel),
      .ram_we_b    (ram_we_b),
      .ram_wdata   (ram_wdata),
      .ram_word    (ram_word)
   );

   // ------------------------------
   // RAM pins
   // ------------------------------

   // Each word sits at an even byte address, the byte select is bit 0
   assign ram_addr = {{(`RAM_ADDR_BITS - 17){1'b0}}, cpu_addr, byte_sel};

   assign ram_cs_b = ext_cs_b;

   // The RAM drives its outputs for every read
   assign ram_oe_b = !cpu_rnw;

   // The controller drives the data pins for every write
   assign ram_wdata_oe = !cpu_rnw;

endmodule

//--- tb_sram_model.sv
`include "mem_ctrl_defs.svh"

// Behavioral 512K x 8 static RAM for the memory controller testbench
module tb_sram_model import mem_ctrl_pkg::*; (
   input  logic                      clock,
   input  logic                      ram_cs_b,
   input  logic                      ram_oe_b,
   input  logic                      ram_we_b,
   input  logic [`RAM_ADDR_BITS-1:0] ram_addr,
   input  byte_t                     ram_wdata,
   input  logic                      ram_wdata_oe,
   output byte_t                     ram_rdata,
   output int                        strobe_errors
);
   timeunit 1ns;
   timeprecision 100ps;

   byte_t mem [1 << `RAM_ADDR_BITS];
   int    err_count = 0;

   // ------------------------------
   // Power-up contents
   // ------------------------------

   // Every byte gets a value folded from all of its address bits, so
   // that the even and odd halves of a word are always told apart
   initial begin
      for (int a = 0; a < (1 << `RAM_ADDR_BITS); a++) begin
         mem[a] = byte_t'(a ^ (a >> 7) ^ (a >> 13) ^ 'h2a5);
      end
   end

   // ------------------------------
   // Write port
   // ------------------------------

   // The strobe is sampled at the clock edge, address and data are
   // stable over the whole byte cycle
   always @(posedge clock) begin
      if (!ram_cs_b && !ram_we_b) begin
         // A strobe is only legal with outputs off and data driven
         if (!ram_oe_b || !ram_wdata_oe) begin
            err_count = err_count + 1;
            $display("[FAIL] %0d ns: write strobe at %h while outputs are enabled",
                     $time, ram_addr);
         end
         mem[ram_addr] = ram_wdata;
      end
   end

   // Reads are asynchronous, the bus floats high when not driven
   assign ram_rdata = (!ram_cs_b && !ram_oe_b) ? mem[ram_addr] : 8'hff;

   assign strobe_errors = err_count;

endmodule

//--- tb_memory_controller.sv
`include "mem_ctrl_defs.svh"

module tb_memory_controller import mem_ctrl_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int    NUM_DIRECTED = 9;
   localparam int    NUM_RANDOM   = 600;
   localparam int    CYCLE_LIMIT  = 16 + 10 * (NUM_DIRECTED + NUM_RANDOM) + 200;
   localparam word_t FETCH_ADDR   = 16'h0a05;
   // Same cache index as FETCH_ADDR with a different tag
   localparam word_t ALIAS_ADDR   = FETCH_ADDR ^ word_t'(1 << `CACHE_INDEX_BITS);

   logic                      clock;
   logic                      reset_b;
   logic                      ext_cs_b;
   logic                      vpa;
   logic                      cpu_rnw;
   word_t                     cpu_addr;
   word_t                     cpu_dout;
   logic                      cpu_clken;
   word_t                     ext_dout;
   logic                      ram_cs_b;
   logic                      ram_oe_b;
   logic                      ram_we_b;
   logic [`RAM_ADDR_BITS-1:0] ram_addr;
   byte_t                     ram_wdata;
   logic                      ram_wdata_oe;
   byte_t                     ram_rdata;
   int                        strobe_errors;

   // Reference model, written words and a shadow of the cache tags
   word_t      written [word_t];
   cache_tag_t model_tag [`CACHE_ENTRIES];
   logic       model_valid [`CACHE_ENTRIES];

   integer seed = 32'h109a7ee8;
   int     error_count = 0;
   int     failed_tests = 0;
   int     cycle = 0;

   memory_controller dut (.*);

   tb_sram_model u_sram (.*);

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   // Watchdog, each access needs at most nine clocks plus one idle
   initial begin
      while (cycle < CYCLE_LIMIT) begin
         @(posedge clock);
         cycle++;
      end
      $display("Timeout: the tests did not finish within %0d clock cycles", cycle);
      $display("TB FAILED");
      $finish;
   end

   // ------------------------------
   // Model helpers
   // ------------------------------

   // Byte address on the RAM for one half of a bus word
   function automatic logic [`RAM_ADDR_BITS-1:0] ram_byte_addr(input word_t addr,
                                                               input logic sel);
      return {{(`RAM_ADDR_BITS - 17){1'b0}}, addr, sel};
   endfunction

   // Power-up contents of the RAM model
   function automatic byte_t ram_fill(input logic [`RAM_ADDR_BITS-1:0] a);
      return byte_t'(a ^ (a >> 7) ^ (a >> 13) ^ 'h2a5);
   endfunction

   // Odd byte is the high half and even byte the low half of a word
   function automatic word_t model_word(input word_t addr);
      if (written.exists(addr)) begin
         return written[addr];
      end
      return {ram_fill(ram_byte_addr(addr, 1'b1)), ram_fill(ram_byte_addr(addr, 1'b0))};
   endfunction

   task automatic report_fail(input string msg);
      error_count++;
      $display("[FAIL] %0d ns: %s", $time, msg);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         $display("Test %s: ok", name);
      end else begin
         failed_tests++;
         $display("Test %s: %0d errors", name, error_count - errors_before);
      end
   endtask

   task automatic idle_cycles(input int n);
      ext_cs_b <= 1'b1;
      repeat (n) @(posedge clock);
   endtask

   // ------------------------------
   // One processor access
   // ------------------------------

   // Called on a rising edge, returns on the edge that completes the access
   task automatic run_access(input logic fetch, input logic rnw, input word_t addr,
                             input word_t wdata, output int stalls, output word_t rdata);
      logic [`CACHE_INDEX_BITS-1:0] idx;
      cache_tag_t                   tag;
      logic                         hit;
      word_t                        expected;
      idx      = addr[`CACHE_INDEX_BITS-1:0];
      tag      = addr[15:`CACHE_INDEX_BITS];
      hit      = fetch && rnw && model_valid[idx] && (model_tag[idx] == tag);
      expected = model_word(addr);
      ext_cs_b <= 1'b0;
      vpa      <= fetch;
      cpu_rnw  <= rnw;
      cpu_addr <= addr;
      cpu_dout <= wdata;
      stalls = 0;
      // Stall cycles are counted in the middle of each clock
      @(negedge clock);
      while (!cpu_clken) begin
         stalls++;
         @(negedge clock);
      end
      rdata = ext_dout;
      @(posedge clock);
      if (stalls != (hit ? 0 : `ACCESS_CYCLES - 1)) begin
         report_fail($sformatf("access to %h stalled %0d cycles, hit expected %b",
                               addr, stalls, hit));
      end
      if (rnw && rdata !== expected) begin
         report_fail($sformatf("read of %h returned %h, expected %h", addr, rdata, expected));
      end
      if (!rnw) begin
         written[addr] = wdata;
      end else if (fetch && !hit) begin
         model_valid[idx] = 1'b1;
         model_tag[idx]   = tag;
      end
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial begin
      word_t data;
      word_t first;
      int    stalls;
      int    errors_before;
      int    r;
      reset_b  <= 1'b0;
      ext_cs_b <= 1'b1;
      vpa      <= 1'b0;
      cpu_rnw  <= 1'b1;
      cpu_addr <= '0;
      cpu_dout <= '0;
      foreach (model_valid[i]) begin
         model_valid[i] = 1'b0;
      end
      repeat (16) @(posedge clock);
      reset_b <= 1'b1;

      errors_before = error_count;
      repeat (2) @(posedge clock);
      @(negedge clock);
      if (!cpu_clken || !ram_we_b || !ram_cs_b) begin
         report_fail($sformatf("idle bus after reset shows cpu_clken %b ram_we_b %b ram_cs_b %b",
                               cpu_clken, ram_we_b, ram_cs_b));
      end
      @(posedge clock);
      finish_test("reset idle", errors_before);

      errors_before = error_count;
      run_access(1'b0, 1'b1, 16'h1234, 16'h0000, stalls, data);
      finish_test("uncached data read", errors_before);

      errors_before = error_count;
      run_access(1'b0, 1'b0, 16'h0456, 16'hbeef, stalls, data);
      if (u_sram.mem[ram_byte_addr(16'h0456, 1'b0)] !== 8'hef ||
          u_sram.mem[ram_byte_addr(16'h0456, 1'b1)] !== 8'hbe) begin
         report_fail("write of beef to 0456 left the wrong bytes in the RAM");
      end
      run_access(1'b0, 1'b1, 16'h0456, 16'h0000, stalls, data);
      if (data !== 16'hbeef) begin
         report_fail($sformatf("read back of 0456 returned %h", data));
      end
      finish_test("write and read back", errors_before);

      errors_before = error_count;
      run_access(1'b1, 1'b1, FETCH_ADDR, 16'h0000, stalls, first);
      run_access(1'b1, 1'b1, FETCH_ADDR, 16'h0000, stalls, data);
      if (stalls != 0 || data !== first) begin
         report_fail($sformatf("repeated fetch stalled %0d cycles and returned %h, not %h",
                               stalls, data, first));
      end
      run_access(1'b1, 1'b1, ALIAS_ADDR, 16'h0000, stalls, data);
      run_access(1'b1, 1'b1, FETCH_ADDR, 16'h0000, stalls, data);
      if (stalls == 0) begin
         report_fail("fetch hit on an entry that an aliased fetch replaced");
      end
      finish_test("fetch miss, hit and replace", errors_before);

      errors_before = error_count;
      run_access(1'b0, 1'b0, FETCH_ADDR, 16'h5aa5, stalls, data);
      run_access(1'b1, 1'b1, FETCH_ADDR, 16'h0000, stalls, data);
      if (stalls != 0 || data !== 16'h5aa5) begin
         report_fail($sformatf("fetch after write stalled %0d cycles and returned %h",
                               stalls, data));
      end
      finish_test("write through to a cached word", errors_before);

      // Four tags times four indices, so hits and aliasing are frequent
      errors_before = error_count;
      repeat (NUM_RANDOM) begin
         r = $random(seed);
         run_access(r[2] | r[3], r[1:0] != 2'b00,
                    {1'b0, r[5:4], 10'b0000100000, r[7:6], 1'b0}, r[31:16], stalls, data);
         if (r[8]) begin
            idle_cycles(1);
         end
      end
      idle_cycles(2);
      if (strobe_errors != 0) begin
         report_fail($sformatf("RAM model saw %0d illegal write strobes", strobe_errors));
      end
      finish_test("random accesses", errors_before);

      $display("Tests run: 6, tests failed: %0d, errors: %0d", failed_tests, error_count);
      if (error_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- build.f
+incdir+.
mem_ctrl_pkg.sv
instr_cache.sv
ext_bus_sequencer.sv
memory_controller.sv
tb_sram_model.sv
tb_memory_controller.sv

//--- run_sim.sh
#!/bin/sh
# Build the memory controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir \
   --top-module tb_memory_controller -f build.f > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_memory_controller > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# The run only counts as passed when the testbench printed its pass line
if grep -q "^TB PASSED$" sim.log; then
   exit 0
fi
echo "Pass line not found in sim.log"
exit 1
